// File: rtl/fofb_pkg.sv
/*
 * Fast orbit feedback link definitions: payload layout, field and
 * state enums, and the byte selection shared by transmit and receive
 */
`default_nettype none

package fofb_pkg;

  localparam logic [7:0] MAGIC_HI = 8'h76;         // identifier, first on the wire
  localparam logic [7:0] MAGIC_LO = 8'h31;
  localparam int HEADER_BYTES  = 12;              // magic + command + nonce
  localparam int RECORD_BYTES  = 6;               // supply number + value
  localparam int PAYLOAD_WIDTH = 32;
  localparam int LENGTH_WIDTH  = 11;              // 1500 byte frame fits
  localparam int NONCE_WIDTH   = 64;
  localparam int CMD_WIDTH     = 4;

  // byte position counts down, 17 at the first magic byte
  localparam int POS_WIDTH = 5;
  localparam logic [POS_WIDTH-1:0] POS_FIRST  = POS_WIDTH'(HEADER_BYTES + RECORD_BYTES - 1);
  localparam logic [POS_WIDTH-1:0] POS_RECORD = POS_WIDTH'(RECORD_BYTES - 1);

  typedef enum logic [2:0] {FLD_MAGIC, FLD_COMMAND, FLD_NONCE, FLD_SUPPLY, FLD_VALUE}
    payload_field_e;
  typedef enum logic [1:0] {TX_IDLE, TX_REQUEST, TX_STREAM} tx_state_e;
  typedef enum logic {RX_WAIT, RX_PARSE} rx_state_e;

  function automatic payload_field_e field_of(input logic [POS_WIDTH-1:0] pos);
    if (pos >= 5'd16) return FLD_MAGIC;
    if (pos >= 5'd14) return FLD_COMMAND;
    if (pos >= 5'd6) return FLD_NONCE;
    if (pos >= 5'd4) return FLD_SUPPLY;
    return FLD_VALUE;
  endfunction

  // expected byte at a position, multibyte fields MSB first
  function automatic logic [7:0] payload_byte(input logic [POS_WIDTH-1:0] pos,
      input logic [CMD_WIDTH-1:0] command, input logic [NONCE_WIDTH-1:0] nonce,
      input logic [7:0] supply, input logic [PAYLOAD_WIDTH-1:0] word);
    int idx;
    idx = int'(pos);
    case (field_of(pos))
      FLD_MAGIC:   return pos[0] ? MAGIC_HI : MAGIC_LO;
      FLD_COMMAND: return pos[0] ? 8'h00 : {{(8 - CMD_WIDTH){1'b0}}, command};
      FLD_NONCE:   return nonce[8 * (idx - 6) +: 8];
      FLD_SUPPLY:  return pos[0] ? 8'h00 : supply;  // supply number high byte is zero
      default:     return word[8 * idx +: 8];
    endcase
  endfunction

endpackage

`default_nettype wire

// File: rtl/fofb_csr_apb.sv
/*
 * APB control registers for the orbit feedback link: readback command,
 * packet number and bad readback packet count
 */
`timescale 1ns/1ps
`default_nettype none

module fofb_csr_apb (
  input  wire logic                             ethClk,
  input  wire logic                             rst_n,
  input  wire logic                             psel,
  input  wire logic                             penable,
  input  wire logic                             pwrite,
  input  wire logic [3:0]                       paddr,
  input  wire logic [31:0]                      pwdata,
  input  wire logic [fofb_pkg::NONCE_WIDTH-1:0] packet_number,
  input  wire logic [15:0]                      error_count,
  output logic [31:0]                           prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  output logic [fofb_pkg::CMD_WIDTH-1:0]        command
);

  import fofb_pkg::*;

  localparam logic [3:0] ADDR_CMD     = 4'h0;
  localparam logic [3:0] ADDR_PKT_LO  = 4'h4;
  localparam logic [3:0] ADDR_PKT_HI  = 4'h8;
  localparam logic [3:0] ADDR_ERR_CNT = 4'hC;

  logic access;
  logic mapped;

  ////////////////////////////////////////////////////////////
  // access decode

  assign access = psel && penable;               // enable phase
  assign mapped = (paddr[1:0] == 2'b00);         // 0x0, 0x4, 0x8, 0xC only

  assign pready  = 1'b1;                         // no wait states
  assign pslverr = access && !mapped;

  ////////////////////////////////////////////////////////////
  // command register

  always_ff @(posedge ethClk or negedge rst_n) begin
    if (!rst_n) begin
      command <= '0;
    end else if (access && pwrite && paddr == ADDR_CMD) begin
      command <= pwdata[CMD_WIDTH-1:0];          // upper bits ignored
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux

  always_comb begin
    case (paddr)
      ADDR_CMD: begin
        prdata = {{(32 - CMD_WIDTH){1'b0}}, command};
      end
      ADDR_PKT_LO: begin
        prdata = packet_number[31:0];
      end
      ADDR_PKT_HI: begin
        prdata = packet_number[63:32];
      end
      ADDR_ERR_CNT: begin
        prdata = {16'h0000, error_count};
      end
      default: begin
        prdata = 32'h0000_0000;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/setpoint_buffer.sv
/*
 * Setpoint packet buffer. Stores one packet of supply setpoints and
 * holds it until the transmitter has sent it; packets arriving meanwhile are dropped
 */
`timescale 1ns/1ps
`default_nettype none

module setpoint_buffer #(
  parameter int MAX_SUPPLIES = 32,
  localparam int ADDR_W = (MAX_SUPPLIES > 1) ? $clog2(MAX_SUPPLIES) : 1
) (
  input  wire logic                               ethClk,
  input  wire logic                               rst_n,
  input  wire logic                               sp_valid,
  input  wire logic                               sp_last,
  input  wire logic [fofb_pkg::PAYLOAD_WIDTH-1:0] sp_data,
  input  wire logic [ADDR_W-1:0]                  rd_index,
  input  wire logic                               tx_done,
  output logic [fofb_pkg::PAYLOAD_WIDTH-1:0]      rd_word,
  output logic                                    buf_full,
  output logic [ADDR_W-1:0]                       buf_last_index
);

  import fofb_pkg::*;

  logic [PAYLOAD_WIDTH-1:0] ram [0:(1 << ADDR_W) - 1];
  logic [ADDR_W-1:0]        waddr;
  logic                     toss;                 // dropping rest of a packet
  logic                     wr_en;

  // a packet that starts while full is tossed as a whole
  assign wr_en = sp_valid && !toss && !buf_full;

  ////////////////////////////////////////////////////////////
  // word storage

  always_ff @(posedge ethClk) begin
    if (wr_en) begin
      ram[waddr] <= sp_data;
      if (sp_last) begin
        buf_last_index <= waddr;                 // index of last supply
      end
    end
  end

  always_ff @(posedge ethClk) begin
    rd_word <= ram[rd_index];                    // one cycle read latency
  end

  ////////////////////////////////////////////////////////////
  // write addressing and packet hand-off

  always_ff @(posedge ethClk or negedge rst_n) begin
    if (!rst_n) begin
      waddr    <= '0;
      toss     <= 1'b0;
      buf_full <= 1'b0;
    end else begin
      if (sp_valid) begin
        if (toss) begin
          if (sp_last) begin
            toss <= 1'b0;
          end
        end else if (buf_full) begin
          toss <= !sp_last;                      // one word packet is already gone
        end else if (sp_last) begin
          waddr    <= '0;
          buf_full <= 1'b1;
        end else begin
          waddr <= waddr + 1'b1;
        end
      end
      if (tx_done) begin
        buf_full <= 1'b0;                        // release for next packet
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/setpoint_transmitter.sv
/*
 * Setpoint transmitter. Requests a UDP packet once the buffer is full
 * and serializes header and supply records, one byte per engine strobe
 */
`timescale 1ns/1ps
`default_nettype none

module setpoint_transmitter #(
  parameter int MAX_SUPPLIES = 32,
  localparam int ADDR_W = (MAX_SUPPLIES > 1) ? $clog2(MAX_SUPPLIES) : 1
) (
  input  wire logic                               ethClk,
  input  wire logic                               rst_n,
  input  wire logic                               buf_full,
  input  wire logic [ADDR_W-1:0]                  buf_last_index,
  input  wire logic [fofb_pkg::PAYLOAD_WIDTH-1:0] rd_word,
  input  wire logic [fofb_pkg::CMD_WIDTH-1:0]     command,
  input  wire logic                               tx_ack,
  input  wire logic                               tx_strobe,
  input  wire logic                               tx_warn,
  output logic [ADDR_W-1:0]                       rd_index,
  output logic                                    tx_done,
  output logic                                    tx_req,
  output logic [fofb_pkg::LENGTH_WIDTH-1:0]       tx_length,
  output logic [7:0]                              tx_data,
  output logic [fofb_pkg::NONCE_WIDTH-1:0]        packet_number
);

  import fofb_pkg::*;

  tx_state_e            state;
  logic [POS_WIDTH-1:0] pos;                     // byte position, counts down
  logic [7:0]           sup_idx;                 // supply being sent

  // next supply is addressed as soon as the record wraps, so the
  // registered RAM word is ready well before the value bytes
  assign rd_index = sup_idx[ADDR_W-1:0];

  assign tx_data = payload_byte(pos, command, packet_number, sup_idx, rd_word);

  // warn low on a strobe closes the packet
  assign tx_done = (state == TX_STREAM) && tx_strobe && !tx_warn;

  ////////////////////////////////////////////////////////////
  // request / stream FSM

  always_ff @(posedge ethClk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= TX_IDLE;
      pos           <= POS_FIRST;
      sup_idx       <= '0;
      tx_req        <= 1'b0;
      tx_length     <= '0;
      packet_number <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          pos     <= POS_FIRST;
          sup_idx <= '0;
          if (buf_full) begin
            tx_req        <= 1'b1;
            packet_number <= packet_number + 1'b1;  // nonce of this packet
            tx_length     <= LENGTH_WIDTH'(HEADER_BYTES +
                                           RECORD_BYTES * (int'(buf_last_index) + 1));
            state         <= TX_REQUEST;
          end
        end

        TX_REQUEST: begin
          if (tx_ack) begin
            tx_req <= 1'b0;
            state  <= TX_STREAM;
          end
        end

        TX_STREAM: begin
          if (tx_strobe) begin
            if (!tx_warn) begin
              state <= TX_IDLE;
            end else if (pos == '0) begin
              pos     <= POS_RECORD;             // wrap to next record
              sup_idx <= sup_idx + 1'b1;
            end else begin
              pos <= pos - 1'b1;
            end
          end
        end

        default: begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/readback_receiver.sv
/*
 * Readback receiver. Checks the returned header against the packet
 * sent, emits one supply/value pair per record and counts bad packets
 */
`timescale 1ns/1ps
`default_nettype none

module readback_receiver (
  input  wire logic                             ethClk,
  input  wire logic                             rst_n,
  input  wire logic                             rx_ready,
  input  wire logic                             rx_strobe,
  input  wire logic [7:0]                       rx_data,
  input  wire logic [fofb_pkg::CMD_WIDTH-1:0]   command,
  input  wire logic [fofb_pkg::NONCE_WIDTH-1:0] packet_number,
  output logic                                  rb_valid,
  output logic [7:0]                            rb_supply,
  output logic [fofb_pkg::PAYLOAD_WIDTH-1:0]    rb_value,
  output logic [15:0]                           error_count
);

  import fofb_pkg::*;

  rx_state_e            state;
  logic [POS_WIDTH-1:0] pos;                     // same count as transmit side
  logic                 bad;                     // header mismatch seen
  logic [7:0]           sup_lo;
  logic [23:0]          val_sr;                  // upper value bytes
  logic [7:0]           expected;

  // supply and word do not matter at the checked positions
  assign expected = payload_byte(pos, command, packet_number, sup_lo, '0);

  ////////////////////////////////////////////////////////////
  // packet tracking and error count

  always_ff @(posedge ethClk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= RX_WAIT;
      pos         <= POS_FIRST;
      bad         <= 1'b0;
      rb_valid    <= 1'b0;
      error_count <= '0;
    end else begin
      rb_valid <= 1'b0;
      case (state)
        RX_WAIT: begin
          if (!rx_ready) begin
            state <= RX_PARSE;
          end
        end
        default: begin
          if (rx_ready) begin
            state <= RX_WAIT;
            if (bad) begin
              error_count <= error_count + 1'b1;
            end
          end
        end
      endcase

      if (rx_ready) begin
        pos <= POS_FIRST;
        bad <= 1'b0;
      end else if (rx_strobe) begin
        pos <= (pos == '0) ? POS_RECORD : pos - 1'b1;
        case (field_of(pos))
          FLD_VALUE: begin
            if (pos == '0) begin
              rb_valid <= 1'b1;                  // record complete
            end
          end
          FLD_SUPPLY: begin
            if (pos[0] && rx_data != expected) begin
              bad <= 1'b1;                       // supply high byte
            end
          end
          default: begin
            if (rx_data != expected) begin
              bad <= 1'b1;
            end
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // record assembly

  always_ff @(posedge ethClk) begin
    if (!rx_ready && rx_strobe) begin
      if (pos == 5'd4) begin
        sup_lo <= rx_data;
      end else if (field_of(pos) == FLD_VALUE) begin
        if (pos == '0) begin
          rb_supply <= sup_lo;
          rb_value  <= {val_sr, rx_data};
        end else begin
          val_sr <= {val_sr[15:0], rx_data};     // MSB first
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/fofb_link_top.sv
/*
 * Fast orbit feedback Ethernet link client. Buffers setpoints, feeds the
 * UDP engine, parses readbacks and exposes control over APB
 */
`timescale 1ns/1ps
`default_nettype none

module fofb_link_top #(
  parameter int MAX_SUPPLIES = 32
) (
  input  wire logic                               ethClk,
  input  wire logic                               rst_n,
  // APB
  input  wire logic                               psel,
  input  wire logic                               penable,
  input  wire logic                               pwrite,
  input  wire logic [3:0]                         paddr,
  input  wire logic [31:0]                        pwdata,
  output logic [31:0]                             prdata,
  output logic                                    pready,
  output logic                                    pslverr,
  // setpoint stream
  input  wire logic                               sp_valid,
  input  wire logic                               sp_last,
  input  wire logic [fofb_pkg::PAYLOAD_WIDTH-1:0] sp_data,
  // UDP engine transmit
  output logic                                    tx_req,
  output logic [fofb_pkg::LENGTH_WIDTH-1:0]       tx_length,
  input  wire logic                               tx_ack,
  input  wire logic                               tx_strobe,
  input  wire logic                               tx_warn,
  output logic [7:0]                              tx_data,
  // UDP engine receive
  input  wire logic                               rx_ready,
  input  wire logic                               rx_strobe,
  input  wire logic [7:0]                         rx_data,
  // readback pairs
  output logic                                    rb_valid,
  output logic [7:0]                              rb_supply,
  output logic [fofb_pkg::PAYLOAD_WIDTH-1:0]      rb_value
);

  import fofb_pkg::*;

  localparam int ADDR_W = (MAX_SUPPLIES > 1) ? $clog2(MAX_SUPPLIES) : 1;

  logic                     buf_full;
  logic [ADDR_W-1:0]        buf_last_index;
  logic [ADDR_W-1:0]        rd_index;
  logic [PAYLOAD_WIDTH-1:0] rd_word;
  logic                     tx_done;
  logic [CMD_WIDTH-1:0]     command;
  logic [NONCE_WIDTH-1:0]   packet_number;
  logic [15:0]              error_count;

  fofb_csr_apb u_csr (
    .ethClk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .packet_number, .error_count, .prdata, .pready, .pslverr, .command
  );

  setpoint_buffer #(.MAX_SUPPLIES(MAX_SUPPLIES)) u_buffer (
    .ethClk, .rst_n, .sp_valid, .sp_last, .sp_data,
    .rd_index, .tx_done, .rd_word, .buf_full, .buf_last_index
  );

  setpoint_transmitter #(.MAX_SUPPLIES(MAX_SUPPLIES)) u_transmitter (
    .ethClk, .rst_n, .buf_full, .buf_last_index, .rd_word, .command,
    .tx_ack, .tx_strobe, .tx_warn, .rd_index, .tx_done,
    .tx_req, .tx_length, .tx_data, .packet_number
  );

  readback_receiver u_receiver (
    .ethClk, .rst_n, .rx_ready, .rx_strobe, .rx_data, .command,
    .packet_number, .rb_valid, .rb_supply, .rb_value, .error_count
  );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
/*
 * Testbench clock and reset source, 4 ns ethClk and a 16 cycle reset
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 2,
  parameter int RESET_CYCLES   = 16
) (
  output logic ethClk,
  output logic rst_n
);

  initial begin
    ethClk = 1'b0;
    forever #(HALF_PERIOD_NS) ethClk = ~ethClk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge ethClk);
    #1 rst_n = 1'b1;                             // release off the edge
  end

endmodule

`default_nettype wire

// File: tests/fofb_link_tb.sv
/*
 * Testbench for the orbit feedback link client. Streams setpoint packets
 * from a case file, models the UDP engine with loopback, checks APB registers
 */
`timescale 1ns/1ps
`default_nettype none

module fofb_link_tb;

  localparam int WAIT_LIMIT = 400;               // cycles allowed per wait loop
  localparam int TOSS_DELAY = 40;                // ack delay that triggers a tossed packet

  logic        ethClk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        sp_valid;
  logic        sp_last;
  logic [31:0] sp_data;
  logic        tx_req;
  logic [10:0] tx_length;
  logic        tx_ack;
  logic        tx_strobe;
  logic        tx_warn;
  logic [7:0]  tx_data;
  logic        rx_ready;
  logic        rx_strobe;
  logic [7:0]  rx_data;
  logic        rb_valid;
  logic [7:0]  rb_supply;
  logic [31:0] rb_value;

  string       test_name;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  bit          aborted;
  logic [63:0] pkt_count;
  logic [15:0] bad_count;
  logic [7:0]  tx_bytes[$];
  logic [7:0]  rb_sup_q[$];
  logic [31:0] rb_val_q[$];

  tb_clock_gen u_clock (.ethClk, .rst_n);

  fofb_link_top #(.MAX_SUPPLIES(32)) dut (
    .ethClk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .pslverr, .sp_valid, .sp_last, .sp_data, .tx_req, .tx_length, .tx_ack, .tx_strobe,
    .tx_warn, .tx_data, .rx_ready, .rx_strobe, .rx_data, .rb_valid, .rb_supply, .rb_value
  );

  always @(negedge ethClk) begin
    if (rb_valid === 1'b1) begin
      rb_sup_q.push_back(rb_supply);              // readback pair capture
      rb_val_q.push_back(rb_value);
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic tick();
    @(posedge ethClk);
    #1;                                          // drive point
  endtask

  task automatic check_value(input string what, input logic [63:0] expected,
      input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Error: %0s %0s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout in test %0s: no %0s within %0d cycles", test_name, what, WAIT_LIMIT);
    aborted = 1'b1;
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors != 0 || aborted) begin
      tests_failed++;
      $display("test %0s failed, %0d errors", test_name, test_errors);
    end else begin
      $display("test %0s passed", test_name);
    end
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    tick();
    penable = 1'b1;
    tick();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    tick();
    penable = 1'b1;
    @(negedge ethClk);                           // enable phase, outputs settled
    data = prdata;
    err  = pslverr;
    check_value("pready", 1, pready);            // zero wait states
    tick();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic stream_words(input int n, input logic [31:0] base, input logic [31:0] step);
    int k;
    for (k = 0; k < n; k++) begin
      sp_valid = 1'b1;
      sp_data  = base + k * step;
      sp_last  = (k == n - 1);
      tick();
    end
    sp_valid = 1'b0;
    sp_last  = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // UDP engine model

  task automatic engine_transmit(input int n, input logic [31:0] base, input logic [31:0] step,
      input int ack_delay);
    int cnt;
    int i;
    int gap;
    int len;
    cnt = 0;
    while (tx_req !== 1'b1 && cnt < WAIT_LIMIT) begin
      tick();
      cnt++;
    end
    if (tx_req !== 1'b1) begin
      note_timeout("transmit request");
      return;
    end
    check_value("tx_length", 12 + 6 * n, tx_length);
    len = int'(tx_length);
    if (ack_delay >= TOSS_DELAY) begin
      stream_words(n, ~base, step);              // arrives while buffer is full
    end
    repeat (ack_delay) tick();
    check_value("tx_req held", 1, tx_req);
    tx_ack = 1'b1;
    tick();
    tx_ack = 1'b0;
    check_value("tx_req after ack", 0, tx_req);
    tx_bytes.delete();
    for (i = 0; i < len; i++) begin
      tx_strobe = 1'b1;
      tx_warn   = 1'b1;
      @(negedge ethClk);
      tx_bytes.push_back(tx_data);
      tick();
      tx_strobe = 1'b0;
      gap = $urandom % 2;
      repeat (gap) tick();
      tick();
    end
    tx_strobe = 1'b1;                            // warn low ends the packet
    tx_warn   = 1'b0;
    tick();
    tx_strobe = 1'b0;
  endtask

  task automatic check_payload(input logic [3:0] cmd, input int n, input logic [31:0] base,
      input logic [31:0] step, input logic [63:0] nonce);
    logic [7:0]  exp_q[$];
    logic [31:0] w;
    int          b;
    int          k;
    int          i;
    exp_q.push_back(8'h76);
    exp_q.push_back(8'h31);
    exp_q.push_back(8'h00);
    exp_q.push_back({4'h0, cmd});
    for (b = 7; b >= 0; b--) begin
      exp_q.push_back(nonce[8 * b +: 8]);
    end
    for (k = 0; k < n; k++) begin
      w = base + k * step;
      exp_q.push_back(8'h00);
      exp_q.push_back(8'(k));
      for (b = 3; b >= 0; b--) begin
        exp_q.push_back(w[8 * b +: 8]);
      end
    end
    check_value("payload bytes", exp_q.size(), tx_bytes.size());
    for (i = 0; i < exp_q.size() && i < tx_bytes.size(); i++) begin
      check_value($sformatf("payload byte %0d", i), exp_q[i], tx_bytes[i]);
    end
  endtask

  task automatic loopback(input int n, input logic [31:0] base, input logic [31:0] step,
      input logic [31:0] mask, input int corrupt);
    logic [7:0]  b;
    logic [31:0] w;
    int          i;
    int          r;
    int          gap;
    int          cnt;
    int          k;
    rb_sup_q.delete();
    rb_val_q.delete();
    rx_ready = 1'b0;
    for (i = 0; i < tx_bytes.size(); i++) begin
      b = tx_bytes[i];
      r = (i - 12) % 6;
      if (i >= 12 && r >= 2) begin
        b = b ^ mask[8 * (5 - r) +: 8];          // value bytes, MSB first
      end
      if (i == 0 && corrupt != 0) begin
        b = ~b;                                  // spoil the magic
      end
      rx_strobe = 1'b1;
      rx_data   = b;
      tick();
      rx_strobe = 1'b0;
      gap = $urandom % 2;
      repeat (gap) tick();
    end
    rx_ready = 1'b1;
    cnt = 0;
    while (rb_sup_q.size() < n && cnt < WAIT_LIMIT) begin
      tick();
      cnt++;
    end
    if (rb_sup_q.size() < n) begin
      note_timeout("complete set of readback pairs");
      return;
    end
    tick();
    check_value("readback count", n, rb_sup_q.size());
    for (k = 0; k < n; k++) begin
      w = (base + k * step) ^ mask;
      check_value($sformatf("rb_supply %0d", k), k, rb_sup_q[k]);
      check_value($sformatf("rb_value %0d", k), w, rb_val_q[k]);
    end
  endtask

  task automatic run_case(input logic [31:0] cmd, input int n, input logic [31:0] base,
      input logic [31:0] step, input logic [31:0] mask, input int ack, input int corrupt);
    logic [31:0] rd;
    logic        err;
    logic [63:0] nonce;
    apb_write(4'h0, cmd);
    apb_read(4'h0, rd, err);
    check_value("command readback", cmd & 32'hF, rd);
    check_value("command pslverr", 0, err);
    stream_words(n, base, step);
    engine_transmit(n, base, step, ack);
    if (aborted) begin
      return;
    end
    pkt_count = pkt_count + 1;
    apb_read(4'h4, rd, err);
    nonce[31:0] = rd;
    apb_read(4'h8, rd, err);
    nonce[63:32] = rd;
    check_value("packet number", pkt_count, nonce);
    check_payload(cmd[3:0], n, base, step, nonce);
    loopback(n, base, step, mask, corrupt);
    if (aborted) begin
      return;
    end
    if (corrupt != 0) begin
      bad_count = bad_count + 1;
    end
    apb_read(4'hC, rd, err);
    check_value("bad packet count", bad_count, rd);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int          fd;
    int          code;
    int          fields;
    int          cnt;
    string       line;
    logic [127:0] name_v;
    logic [31:0] cmd_v;
    logic [31:0] base_v;
    logic [31:0] step_v;
    logic [31:0] mask_v;
    logic [31:0] rd;
    logic        err;
    int          n_v;
    int          ack_v;
    int          corrupt_v;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 4'h0;
    pwdata = 32'h0;
    sp_valid = 1'b0;
    sp_last = 1'b0;
    sp_data = 32'h0;
    tx_ack = 1'b0;
    tx_strobe = 1'b0;
    tx_warn = 1'b0;
    rx_ready = 1'b1;                             // idle receive port
    rx_strobe = 1'b0;
    rx_data = 8'h00;
    tests_run = 0;
    tests_failed = 0;
    aborted = 1'b0;
    pkt_count = '0;
    bad_count = '0;
    void'($urandom(81));
    test_name = "reset";
    cnt = 0;
    while (rst_n !== 1'b1 && cnt < WAIT_LIMIT) begin
      @(posedge ethClk);
      cnt++;
    end
    if (rst_n !== 1'b1) begin
      note_timeout("reset release");
    end else begin
      tick();
      begin_test("reset_defaults");
      check_value("tx_req", 0, tx_req);
      check_value("rb_valid", 0, rb_valid);
      check_value("pslverr", 0, pslverr);
      apb_read(4'h0, rd, err);
      check_value("command", 0, rd);
      apb_read(4'h4, rd, err);
      check_value("packet number low", 0, rd);
      apb_read(4'h8, rd, err);
      check_value("packet number high", 0, rd);
      apb_read(4'hC, rd, err);
      check_value("bad packet count", 0, rd);
      end_test();

      begin_test("apb_map");
      apb_write(4'h4, 32'hFFFF_FFFF);            // read only, ignored
      apb_write(4'hC, 32'h0000_FFFF);
      apb_read(4'h4, rd, err);
      check_value("packet number after write", 0, rd);
      check_value("pslverr at 0x4", 0, err);
      apb_read(4'hC, rd, err);
      check_value("bad count after write", 0, rd);
      apb_read(4'h2, rd, err);
      check_value("pslverr at 0x2", 1, err);
      apb_read(4'h7, rd, err);
      check_value("pslverr at 0x7", 1, err);
      apb_write(4'h0, 32'h0000_0009);
      apb_read(4'h0, rd, err);
      check_value("command readback", 9, rd);
      end_test();

      fd = $fopen("tests/fofb_link_cases.txt", "r");
      if (fd == 0) begin
        $display("Cannot open the case file tests/fofb_link_cases.txt");
        aborted = 1'b1;
      end else begin
        while (!aborted && !$feof(fd)) begin
          code = $fgets(line, fd);
          if (code > 0 && line[0] != "#") begin
            fields = $sscanf(line, "%s %h %d %h %h %h %d %d", name_v, cmd_v, n_v,
                             base_v, step_v, mask_v, ack_v, corrupt_v);
            if (fields == 8) begin
              begin_test($sformatf("%0s", name_v));
              run_case(cmd_v, n_v, base_v, step_v, mask_v, ack_v, corrupt_v);
              end_test();
            end
          end
        end
        $fclose(fd);
      end
    end

    $display("tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0 && !aborted && tests_run > 2) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fofb_link.f
rtl/fofb_pkg.sv
rtl/fofb_csr_apb.sv
rtl/setpoint_buffer.sv
rtl/setpoint_transmitter.sv
rtl/readback_receiver.sv
rtl/fofb_link_top.sv
tests/tb_clock_gen.sv
tests/fofb_link_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the orbit feedback link testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f fofb_link.f \
  --top-module fofb_link_tb -o fofb_link_sim &&
./obj_dir/fofb_link_sim | tee /dev/stderr | grep -qF "RESULT: PASS" ||
{ echo "simulation did not pass" >&2; exit 1; }

// File: tests/fofb_link_cases.txt
# name cmd(hex) words base(hex) step(hex) xor_mask(hex) ack_delay corrupt
# ack delays of 40 or more also stream a second packet during the wait, which must be tossed
single      1  1  12345678 00000000 00000000 0  0
pair        2  2  00000100 00000001 ffffffff 3  0
ramp8       3  8  a0000000 01010101 0000ffff 1  0
toss_first  4  4  11111111 11111111 00000000 60 0
after_toss  5  5  cafe0000 00000010 12345678 2  0
corrupt     6  3  00c0ffee 00001000 00000000 0  1
clean_after 7  6  80000000 fffffff0 a5a5a5a5 5  0
full32      f  32 00000000 07654321 00ff00ff 8  0
cmd_wide    5a 2  deadbeef 00000000 ffff0000 0  0
toss_long   9  16 01234567 89abcdef 0f0f0f0f 80 0
after_long  0  1  fffffffe 00000001 00000001 4  0
corrupt2    c  7  55555555 aaaaaaaa 00000000 45 1
final       b  10 00000010 00000010 80808080 2  0
